/* hdl/hmc_rx_pkg.sv */
package hmc_rx_pkg;

    // ------------------------------------------------------------
    // FLIT geometry
    // ------------------------------------------------------------

    // FLITs carried per beat
    localparam int FPW = 4;
    // Bits per FLIT
    localparam int FLIT_W = 128;

    // ------------------------------------------------------------
    // Header field positions
    // ------------------------------------------------------------

    // Command, bits 5..0
    localparam int CMD_LSB = 0;
    // Length in FLITs, bits 10..7
    localparam int LNG_LSB = 7;
    // Tag, bits 23..15
    localparam int TAG_LSB = 15;

    // ------------------------------------------------------------
    // Types
    // ------------------------------------------------------------

    typedef logic [FLIT_W-1:0] flit_t;
    // One flag per FLIT slot
    typedef logic [FPW-1:0]    flit_mask_t;

    typedef logic [5:0]        hmc_cmd_t;
    typedef logic [3:0]        hmc_lng_t;
    typedef logic [8:0]        hmc_tag_t;

    // One beat, slot 0 is first in time
    typedef struct packed {
        flit_t [FPW-1:0] data;
        flit_mask_t      valid;
        flit_mask_t      hdr;
        flit_mask_t      tail;
    } rx_beat_t;

    // One descriptor per closed packet
    typedef struct packed {
        hmc_cmd_t cmd;
        hmc_lng_t lng;
        hmc_tag_t tag;
        hmc_lng_t flit_cnt;   // FLITs actually seen
        logic     len_err;
        logic     frm_err;
    } pkt_desc_t;

endpackage

/* hdl/hmc_rx_pkt_serializer.sv */
module hmc_rx_pkt_serializer (
    input  logic                 clk,
    input  logic                 res_n,

    // Beat input
    input  hmc_rx_pkg::rx_beat_t i_in_beat,
    input  logic                 i_in_valid,
    output logic                 o_in_ready,

    // Beat output, one packet start per beat
    output hmc_rx_pkg::rx_beat_t o_out_beat,
    output logic                 o_out_valid,
    input  logic                 i_out_ready
);

    // ------------------------------------------------------------
    // Signals
    // ------------------------------------------------------------

    // Held beat and the slots of it still to be sent
    hmc_rx_pkg::rx_beat_t   buf_beat;
    hmc_rx_pkg::flit_mask_t pend;
    hmc_rx_pkg::flit_mask_t pend_nxt;

    logic                   use_buf;
    logic                   in_fire;
    // Output register free to take a new beat
    logic                   advance;

    // Beat under scan this cycle
    hmc_rx_pkg::rx_beat_t   src_beat;
    hmc_rx_pkg::flit_mask_t src_avail;

    // Scan results
    hmc_rx_pkg::flit_mask_t keep;
    hmc_rx_pkg::flit_mask_t rem;
    logic                   hdr_seen;
    logic                   tail_seen;
    logic                   stall;

    // ------------------------------------------------------------
    // Split scan
    // ------------------------------------------------------------

    assign use_buf = |pend;
    assign in_fire = i_in_valid && o_in_ready;
    assign advance = !o_out_valid || i_out_ready;

    always_comb begin
        // Buffer wins while parts of it remain
        if (use_buf) begin
            src_beat  = buf_beat;
            src_avail = pend;
        end else begin
            src_beat  = i_in_beat;
            src_avail = '1;
        end

        hdr_seen  = 1'b0;
        tail_seen = 1'b0;
        stall     = 1'b0;
        keep      = '0;

        for (int i = 0; i < hmc_rx_pkg::FPW; i++) begin
            // Second header, or header after a tail, cuts here
            if (src_avail[i] && src_beat.valid[i] && src_beat.hdr[i]) begin
                if (hdr_seen || tail_seen) begin
                    stall = 1'b1;
                end
                hdr_seen = 1'b1;
            end
            // Tail checked after header so 1-FLIT packets pass
            if (src_avail[i] && src_beat.valid[i] && src_beat.tail[i]) begin
                tail_seen = 1'b1;
            end
            keep[i] = src_avail[i] && !stall;
        end

        // Slots left for a later part
        rem = src_avail & ~keep;
    end

    // Pending slots for next cycle
    always_comb begin
        pend_nxt = pend;
        if (use_buf) begin
            if (advance) begin
                pend_nxt = rem;
            end
        end else if (in_fire) begin
            // Output stalled, park the whole beat
            pend_nxt = advance ? rem : '1;
        end
    end

    // ------------------------------------------------------------
    // Control registers
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge res_n) begin
        if (!res_n) begin
            pend        <= '0;
            o_in_ready  <= 1'b0;
            o_out_valid <= 1'b0;
        end else begin
            pend <= pend_nxt;
            // Only take input with an empty buffer and a free sink
            o_in_ready <= (pend_nxt == '0) && i_out_ready;
            if (advance) begin
                o_out_valid <= use_buf || in_fire;
            end
        end
    end

    // ------------------------------------------------------------
    // Data registers
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        // Buffer is always empty when input is accepted
        if (in_fire) begin
            buf_beat <= i_in_beat;
        end
        if (advance && (use_buf || in_fire)) begin
            // Data whole, flags cut to the kept slots
            o_out_beat.data  <= src_beat.data;
            o_out_beat.valid <= src_beat.valid & keep;
            o_out_beat.hdr   <= src_beat.hdr & keep;
            o_out_beat.tail  <= src_beat.tail & keep;
        end
    end

endmodule

/* hdl/hmc_rx_pkt_decoder.sv */
module hmc_rx_pkt_decoder (
    input  logic                  clk,
    input  logic                  res_n,

    // Serialized beats
    input  hmc_rx_pkg::rx_beat_t  i_beat,
    input  logic                  i_beat_valid,
    output logic                  o_beat_ready,

    // Packet descriptors
    output hmc_rx_pkg::pkt_desc_t o_desc,
    output logic                  o_desc_valid,
    input  logic                  i_desc_ready
);

    typedef enum logic {
        IDLE,
        IN_PKT
    } state_t;

    // ------------------------------------------------------------
    // Signals
    // ------------------------------------------------------------

    state_t                state;
    state_t                state_nxt;

    // Open packet
    hmc_rx_pkg::hmc_cmd_t  cur_cmd;
    hmc_rx_pkg::hmc_lng_t  cur_lng;
    hmc_rx_pkg::hmc_tag_t  cur_tag;
    hmc_rx_pkg::hmc_lng_t  cnt;
    hmc_rx_pkg::hmc_lng_t  cnt_nxt;

    logic                  beat_fire;
    logic                  has_hdr;
    logic                  has_tail;
    logic                  before_hdr;
    hmc_rx_pkg::flit_t     hdr_flit;
    // Valid FLITs before and from the header on
    hmc_rx_pkg::hmc_lng_t  cnt_pre;
    hmc_rx_pkg::hmc_lng_t  cnt_post;

    logic                  load_hdr;
    logic                  emit;
    hmc_rx_pkg::pkt_desc_t desc_nxt;

    assign o_beat_ready = !o_desc_valid || i_desc_ready;
    assign beat_fire    = i_beat_valid && o_beat_ready;
    assign has_hdr      = |(i_beat.valid & i_beat.hdr);
    assign has_tail     = |(i_beat.valid & i_beat.tail);

    // ------------------------------------------------------------
    // Header pick and FLIT counts
    // ------------------------------------------------------------

    always_comb begin
        before_hdr = 1'b1;
        hdr_flit   = i_beat.data[0];
        cnt_pre    = '0;
        cnt_post   = '0;
        for (int i = 0; i < hmc_rx_pkg::FPW; i++) begin
            // At most one header per beat after the serializer
            if (i_beat.valid[i] && i_beat.hdr[i] && before_hdr) begin
                hdr_flit   = i_beat.data[i];
                before_hdr = 1'b0;
            end
            if (i_beat.valid[i]) begin
                if (before_hdr) begin
                    cnt_pre = cnt_pre + 1'b1;
                end else begin
                    cnt_post = cnt_post + 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Packet state
    // ------------------------------------------------------------

    always_comb begin
        state_nxt = state;
        cnt_nxt   = cnt;
        load_hdr  = 1'b0;
        emit      = 1'b0;

        // Default closes the open packet
        desc_nxt.cmd      = cur_cmd;
        desc_nxt.lng      = cur_lng;
        desc_nxt.tag      = cur_tag;
        desc_nxt.flit_cnt = cnt + cnt_pre;
        desc_nxt.frm_err  = 1'b0;

        if (beat_fire) begin
            case (state)
                IDLE: begin
                    if (has_hdr) begin
                        load_hdr = 1'b1;
                        if (has_tail) begin
                            // Whole packet inside this beat
                            emit              = 1'b1;
                            desc_nxt.cmd      = hdr_flit[hmc_rx_pkg::CMD_LSB +: 6];
                            desc_nxt.lng      = hdr_flit[hmc_rx_pkg::LNG_LSB +: 4];
                            desc_nxt.tag      = hdr_flit[hmc_rx_pkg::TAG_LSB +: 9];
                            desc_nxt.flit_cnt = cnt_post;
                        end else begin
                            state_nxt = IN_PKT;
                            cnt_nxt   = cnt_post;
                        end
                    end else if (has_tail) begin
                        // Tail with no open packet
                        emit             = 1'b1;
                        desc_nxt.frm_err = 1'b1;
                    end
                end
                IN_PKT: begin
                    if (has_hdr) begin
                        // New header cuts the open packet short
                        emit             = 1'b1;
                        desc_nxt.frm_err = 1'b1;
                        load_hdr         = 1'b1;
                        cnt_nxt          = cnt_post;
                        // New packet closing here too is dropped, framing resyncs
                        if (has_tail) begin
                            state_nxt = IDLE;
                            cnt_nxt   = '0;
                        end
                    end else if (has_tail) begin
                        emit      = 1'b1;
                        state_nxt = IDLE;
                        cnt_nxt   = '0;
                    end else begin
                        cnt_nxt = cnt + cnt_pre;
                    end
                end
                default: state_nxt = IDLE;
            endcase
        end

        desc_nxt.len_err = desc_nxt.flit_cnt != desc_nxt.lng;
    end

    // ------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge res_n) begin
        if (!res_n) begin
            state        <= IDLE;
            cnt          <= '0;
            o_desc_valid <= 1'b0;
        end else begin
            state <= state_nxt;
            cnt   <= cnt_nxt;
            if (emit) begin
                o_desc_valid <= 1'b1;
            end else if (i_desc_ready) begin
                o_desc_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_hdr) begin
            cur_cmd <= hdr_flit[hmc_rx_pkg::CMD_LSB +: 6];
            cur_lng <= hdr_flit[hmc_rx_pkg::LNG_LSB +: 4];
            cur_tag <= hdr_flit[hmc_rx_pkg::TAG_LSB +: 9];
        end
        if (emit) begin
            o_desc <= desc_nxt;
        end
    end

endmodule

/* hdl/hmc_rx_top.sv */
module hmc_rx_top (
    input  logic                  clk,
    input  logic                  res_n,

    // Beats from the link
    input  hmc_rx_pkg::rx_beat_t  i_beat,
    input  logic                  i_beat_valid,
    output logic                  o_beat_ready,

    // Descriptors out, in arrival order
    output hmc_rx_pkg::pkt_desc_t o_desc,
    output logic                  o_desc_valid,
    input  logic                  i_desc_ready
);

    // ------------------------------------------------------------
    // Serializer to decoder
    // ------------------------------------------------------------

    hmc_rx_pkg::rx_beat_t ser_beat;
    logic                 ser_valid;
    logic                 ser_ready;

    // Split beats to one packet start each
    hmc_rx_pkt_serializer u_serializer (
        .clk         (clk),
        .res_n       (res_n),
        .i_in_beat   (i_beat),
        .i_in_valid  (i_beat_valid),
        .o_in_ready  (o_beat_ready),
        .o_out_beat  (ser_beat),
        .o_out_valid (ser_valid),
        .i_out_ready (ser_ready)
    );

    // Header parse and FLIT count
    hmc_rx_pkt_decoder u_decoder (
        .clk          (clk),
        .res_n        (res_n),
        .i_beat       (ser_beat),
        .i_beat_valid (ser_valid),
        .o_beat_ready (ser_ready),
        .o_desc       (o_desc),
        .o_desc_valid (o_desc_valid),
        .i_desc_ready (i_desc_ready)
    );

endmodule

/* tb/tb_hmc_rx_model.svh */
`ifndef TB_HMC_RX_MODEL_SVH
`define TB_HMC_RX_MODEL_SVH

// ------------------------------------------------------------
// Packet stream model
// ------------------------------------------------------------

// FLITs waiting to be packed
// Flags per FLIT are {break after, tail, header}
hmc_rx_pkg::flit_t     flit_q[$];
logic [2:0]            flag_q[$];
// Beats to drive, idle cycles after each, descriptors to expect
hmc_rx_pkg::rx_beat_t  beat_q[$];
int                    gap_q[$];
hmc_rx_pkg::pkt_desc_t exp_q[$];

function automatic int rand_range(int lo, int hi);
    return lo + int'({$random(seed)} % (hi - lo + 1));
endfunction

function automatic hmc_rx_pkg::flit_t rand_flit();
    hmc_rx_pkg::flit_t f;
    for (int w = 0; w < hmc_rx_pkg::FLIT_W / 32; w++) begin
        f[32*w +: 32] = $random(seed);
    end
    return f;
endfunction

// One packet of len FLITs with header first and tail last
task automatic add_packet(int len, bit bad, bit brk);
    hmc_rx_pkg::pkt_desc_t d;
    hmc_rx_pkg::flit_t     f;
    d.cmd      = hmc_rx_pkg::hmc_cmd_t'(rand_range(0, 63));
    d.tag      = hmc_rx_pkg::hmc_tag_t'(rand_range(0, 511));
    // Offset of 1..15 mod 16 never lands on the true length
    d.lng      = hmc_rx_pkg::hmc_lng_t'(bad ? len + rand_range(1, 15) : len);
    d.flit_cnt = hmc_rx_pkg::hmc_lng_t'(len);
    d.len_err  = bad;
    d.frm_err  = 1'b0;
    exp_q.push_back(d);
    for (int i = 0; i < len; i++) begin
        f = rand_flit();
        if (i == 0) begin
            // Header fields at cmd 5..0, lng 10..7 and tag 23..15
            f[5:0]   = d.cmd;
            f[10:7]  = d.lng;
            f[23:15] = d.tag;
        end
        flit_q.push_back(f);
        flag_q.push_back({brk && (i == len - 1), i == len - 1, i == 0});
    end
endtask

// Pack back to back into beats from slot 0
task automatic pack_beats();
    hmc_rx_pkg::rx_beat_t b;
    logic [2:0]           fl;
    int                   slot;
    b    = '0;
    slot = 0;
    while (flit_q.size() > 0) begin
        fl            = flag_q.pop_front();
        b.data[slot]  = flit_q.pop_front();
        b.valid[slot] = 1'b1;
        b.hdr[slot]   = fl[0];
        b.tail[slot]  = fl[1];
        slot++;
        // Full beat, forced break, random short beat or end of stream
        if (slot == hmc_rx_pkg::FPW || fl[2] || rand_range(0, 9) == 0 || flit_q.size() == 0) begin
            beat_q.push_back(b);
            gap_q.push_back(rand_range(0, 3) == 0 ? rand_range(1, 3) : 0);
            b    = '0;
            slot = 0;
        end
    end
endtask

`endif

/* tb/tb_hmc_rx.sv */
module tb_hmc_rx;

    // Cycles any single wait may take
    localparam int TIMEOUT = 1000;

    logic                  clk;
    logic                  res_n;
    hmc_rx_pkg::rx_beat_t  i_beat;
    logic                  i_beat_valid;
    logic                  o_beat_ready;
    hmc_rx_pkg::pkt_desc_t o_desc;
    logic                  o_desc_valid;
    logic                  i_desc_ready;

    integer seed = 32'hf27b;
    string  test_name;
    // Sink stall chance in percent
    int     bp_pct;
    logic   stalled;

    `include "tb_hmc_rx_model.svh"

    hmc_rx_top UUT (
        .clk          (clk),
        .res_n        (res_n),
        .i_beat       (i_beat),
        .i_beat_valid (i_beat_valid),
        .o_beat_ready (o_beat_ready),
        .o_desc       (o_desc),
        .o_desc_valid (o_desc_valid),
        .i_desc_ready (i_desc_ready)
    );

    // ------------------------------------------------------------
    // Reporting and compares
    // ------------------------------------------------------------

    task automatic fail_stop(string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    function automatic string desc_str(hmc_rx_pkg::pkt_desc_t d);
        return $sformatf("cmd=%h lng=%h tag=%h cnt=%h len_err=%b frm_err=%b",
                         d.cmd, d.lng, d.tag, d.flit_cnt, d.len_err, d.frm_err);
    endfunction

    task automatic compare_desc(hmc_rx_pkg::pkt_desc_t exp, hmc_rx_pkg::pkt_desc_t act);
        if (act !== exp) begin
            fail_stop($sformatf("[FAIL] %s: expected %s, actual %s",
                                test_name, desc_str(exp), desc_str(act)));
        end
    endtask

    task automatic compare_flag(string what, logic exp, logic act);
        if (act !== exp) begin
            fail_stop($sformatf("[FAIL] %s: %s expected %b actual %b",
                                test_name, what, exp, act));
        end
    endtask

    // ------------------------------------------------------------
    // Clock and descriptor sink
    // ------------------------------------------------------------

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Outputs are registered, so values at the falling edge hold to the next rise
    initial begin
        i_desc_ready = 1'b1;
        stalled      = 1'b0;
        forever begin
            @(negedge clk);
            // Decoder stalled last edge so the beat input must be closed now
            if (stalled) begin
                compare_flag("o_beat_ready after stall", 1'b0, o_beat_ready);
            end
            i_desc_ready = rand_range(0, 99) >= bp_pct;
            stalled      = o_desc_valid && !i_desc_ready;
            if (o_desc_valid && i_desc_ready) begin
                if (exp_q.size() == 0) begin
                    fail_stop("a descriptor arrived with no packet left to account for");
                end
                compare_desc(exp_q.pop_front(), o_desc);
            end
        end
    end

    // ------------------------------------------------------------
    // Beat driver
    // ------------------------------------------------------------

    // Called at a falling edge
    task automatic send_beats();
        int wait_cnt;
        int gap;
        while (beat_q.size() > 0) begin
            i_beat       = beat_q.pop_front();
            i_beat_valid = 1'b1;
            gap          = gap_q.pop_front();
            wait_cnt     = 0;
            while (!o_beat_ready) begin
                @(negedge clk);
                wait_cnt++;
                if (wait_cnt > TIMEOUT) begin
                    fail_stop("beat input never became ready");
                end
            end
            // Taken on the coming rising edge
            @(negedge clk);
            i_beat_valid = 1'b0;
            repeat (gap) @(negedge clk);
        end
    endtask

    task automatic run_phase(string name, int n_pkts, int min_len, int max_len,
                             bit one_per_beat, int bad_pct, int stall_pct);
        int wait_cnt;
        int len;
        bit bad;
        // Build on a rising edge away from the sink's random draws
        @(posedge clk);
        test_name = name;
        bp_pct    = stall_pct;
        for (int p = 0; p < n_pkts; p++) begin
            len = rand_range(min_len, max_len);
            bad = rand_range(0, 99) < bad_pct;
            add_packet(len, bad, one_per_beat);
        end
        pack_beats();
        @(negedge clk);
        send_beats();
        wait_cnt = 0;
        while (exp_q.size() > 0) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > TIMEOUT) begin
                fail_stop($sformatf("%s: no descriptor arrived, %0d still outstanding",
                                    name, exp_q.size()));
            end
        end
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------

    initial begin
        res_n        = 1'b0;
        i_beat       = '0;
        i_beat_valid = 1'b0;
        bp_pct       = 0;
        test_name    = "idle_after_reset";
        repeat (8) @(posedge clk);
        @(negedge clk);
        res_n = 1'b1;
        // No input yet so nothing may come out
        repeat (20) begin
            @(negedge clk);
            compare_flag("o_desc_valid", 1'b0, o_desc_valid);
        end

        run_phase("single_pkt", 20, 1, 4, 1'b1, 0, 0);
        run_phase("multi_pkt", 40, 1, 2, 1'b0, 0, 0);
        run_phase("span_pkt", 30, 3, 4, 1'b0, 0, 0);
        run_phase("len_err", 20, 1, 4, 1'b0, 100, 0);
        run_phase("backpressure", 200, 1, 4, 1'b0, 20, 50);

        // Any extra descriptor in the quiet tail trips the sink
        bp_pct = 0;
        repeat (20) @(negedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* build.f */
+incdir+tb
hdl/hmc_rx_pkg.sv
hdl/hmc_rx_pkt_serializer.sv
hdl/hmc_rx_pkt_decoder.sv
hdl/hmc_rx_top.sv
tb/tb_hmc_rx.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_hmc_rx
FILELIST  := build.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := *** TEST PASSED ***

SOURCES := $(wildcard hdl/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
